// ==== common/commitPkg.sv ====
package commitPkg;

    parameter logic [31:0] EXC_VECTOR = 32'hBFC0_0380;  // General exception entry.

    // Decoded micro-op as written by dispatch.
    typedef struct packed {
        logic [31:0] pc;
        logic        isBranch;
        logic        predTaken;
        logic [31:0] predTarget;
        logic [4:0]  dstArch;
        logic [5:0]  dstPhys;
        logic [5:0]  staleDstPhys;  // Mapping freed at commit.
        logic        writesDst;
    } uopDesc;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } branchResult;

    typedef struct packed {
        logic [12:0] pad;
        logic [19:0] excCode;
    } excResult;

    // Read as branch outcome or exception code, by isBranch.
    typedef union packed {
        branchResult branch;
        excResult    exc;
    } resultWord;

    typedef struct packed {
        logic      causeExc;
        resultWord result;
    } completionInfo;

    typedef struct packed {
        logic          complete;
        uopDesc        uop;
        completionInfo info;
    } robSlot;

    // Two oldest entries, slot0 is the head.
    typedef struct packed {
        logic   present0;
        robSlot slot0;
        logic   present1;
        robSlot slot1;
    } commitWindow;

    typedef struct packed {
        logic [4:0] committedArf;
        logic [5:0] committedPrf;
        logic [5:0] stalePrf;
        logic       wrRegCommit;
    } commitReq;

endpackage

// ==== hw/dispatchUnit.sv ====
module dispatchUnit #(
    parameter int ROB_DEPTH = 8
) (
    input  logic              clk,
    input  logic              arstN,

    input  logic              instValid,
    input  commitPkg::uopDesc instIn,
    output logic              instReady,

    input  logic [1:0]        creditReturn,
    input  logic              flush,

    output logic              allocValid,
    output commitPkg::uopDesc allocUop
);

    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    logic [CNT_W-1:0] creditCnt;
    logic             creditAvail;

    assign creditAvail = creditCnt != '0;

    // No new work while the back end is being flushed.
    assign instReady  = creditAvail && !flush;
    assign allocValid = instValid && instReady;
    assign allocUop   = instIn;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            creditCnt <= CNT_W'(ROB_DEPTH);
        end else if (flush) begin
            creditCnt <= CNT_W'(ROB_DEPTH);  // Buffer is empty again.
        end else begin
            creditCnt <= creditCnt - CNT_W'(allocValid) + CNT_W'(creditReturn);
        end
    end

endmodule

// ==== rob/reorderBuffer.sv ====
module reorderBuffer #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         arstN,

    input  logic                         allocValid,
    input  commitPkg::uopDesc            allocUop,

    input  logic                         compValid,
    input  logic [$clog2(ROB_DEPTH)-1:0] compTag,
    input  commitPkg::completionInfo     compInfo,

    output commitPkg::commitWindow       window,
    input  logic [1:0]                   popCount,
    input  logic                         flush,

    output logic [1:0]                   creditReturn
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    commitPkg::uopDesc        uops [ROB_DEPTH];
    commitPkg::completionInfo infos[ROB_DEPTH];

    logic [ROB_DEPTH-1:0] validBits;
    logic [ROB_DEPTH-1:0] completeBits;
    logic [TAG_W-1:0]     headPtr;
    logic [TAG_W-1:0]     headNext;
    logic [TAG_W-1:0]     tailPtr;
    logic                 compHit;

    assign headNext = headPtr + TAG_W'(1);
    assign compHit  = compValid && validBits[compTag];  // Stale tags dropped.

    assign creditReturn = popCount;

    always_comb begin
        window.present0       = validBits[headPtr];
        window.slot0.complete = completeBits[headPtr];
        window.slot0.uop      = uops[headPtr];
        window.slot0.info     = infos[headPtr];
        window.present1       = validBits[headNext];
        window.slot1.complete = completeBits[headNext];
        window.slot1.uop      = uops[headNext];
        window.slot1.info     = infos[headNext];
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validBits    <= '0;
            completeBits <= '0;
            headPtr      <= '0;
            tailPtr      <= '0;
        end else if (flush) begin
            validBits    <= '0;
            completeBits <= '0;
            headPtr      <= '0;  // Tags restart at zero.
            tailPtr      <= '0;
        end else begin
            if (allocValid) begin
                validBits[tailPtr]    <= 1'b1;
                completeBits[tailPtr] <= 1'b0;
                tailPtr               <= tailPtr + TAG_W'(1);
            end
            if (compHit) begin
                completeBits[compTag] <= 1'b1;
            end
            if (popCount != 2'd0) begin
                validBits[headPtr]    <= 1'b0;
                completeBits[headPtr] <= 1'b0;
            end
            if (popCount == 2'd2) begin
                validBits[headNext]    <= 1'b0;
                completeBits[headNext] <= 1'b0;
            end
            headPtr <= headPtr + TAG_W'(popCount);
        end
    end

    // Entry payload.
    always_ff @(posedge clk) begin
        if (allocValid) begin
            uops[tailPtr] <= allocUop;
        end
        if (compHit) begin
            infos[compTag] <= compInfo;
        end
    end

endmodule

// ==== hw/commitStage.sv ====
module commitStage (
    input  logic                  clk,
    input  logic                  arstN,

    input  commitPkg::commitWindow window,
    output logic [1:0]            popCount,
    output logic                  flush,

    output logic                  renameValid0,
    output logic                  renameValid1,
    output commitPkg::commitReq   renameReq0,
    output commitPkg::commitReq   renameReq1,

    output logic                  redirectValid,
    output logic [31:0]           redirectPc,

    output logic                  exceptionValid,
    output logic [19:0]           excCode
);

    commitPkg::robSlot      slot0;
    commitPkg::robSlot      slot1;
    commitPkg::branchResult brRes;
    logic                   ready0;
    logic                   ready1;
    logic                   retire0;
    logic                   retire1;
    logic                   branchRetire;
    logic                   dirMiss;
    logic                   addrMiss;
    logic                   exc0;
    logic                   exc1;
    logic [31:0]            branchPc;
    logic [31:0]            redirectPcNext;
    logic [19:0]            excCodeNext;

    function automatic commitPkg::commitReq toReq(input commitPkg::uopDesc uop);
        commitPkg::commitReq req;
        req.committedArf = uop.dstArch;
        req.committedPrf = uop.dstPhys;
        req.stalePrf     = uop.staleDstPhys;
        req.wrRegCommit  = uop.writesDst;
        return req;
    endfunction

    assign slot0  = window.slot0;
    assign slot1  = window.slot1;
    assign ready0 = window.present0 && slot0.complete;
    assign ready1 = window.present1 && slot1.complete;

    always_comb begin
        retire0 = 1'b0;
        retire1 = 1'b0;
        if (ready0) begin
            if (slot0.info.causeExc) begin
                retire0 = 1'b1;  // Retires alone.
            end else if (slot0.uop.isBranch) begin
                retire0 = ready1;  // Waits for its delay slot.
                retire1 = ready1;
            end else begin
                retire0 = 1'b1;
                retire1 = ready1 && !slot1.uop.isBranch && !slot1.info.causeExc;
            end
        end
    end

    assign brRes        = slot0.info.result.branch;
    assign branchRetire = retire1 && slot0.uop.isBranch;
    assign dirMiss      = brRes.taken != slot0.uop.predTaken;
    assign addrMiss     = brRes.taken && (brRes.target != slot0.uop.predTarget);
    assign exc0         = retire0 && slot0.info.causeExc;
    assign exc1         = retire1 && slot1.info.causeExc;  // Faulting delay slot.

    assign branchPc       = brRes.taken ? brRes.target : slot0.uop.pc + 32'd8;
    assign redirectPcNext = (exc0 || exc1) ? commitPkg::EXC_VECTOR : branchPc;
    assign excCodeNext    = exc0 ? slot0.info.result.exc.excCode
                                 : slot1.info.result.exc.excCode;

    assign popCount = {1'b0, retire0} + {1'b0, retire1};
    assign flush    = (branchRetire && (dirMiss || addrMiss)) || exc0 || exc1;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            renameValid0   <= 1'b0;
            renameValid1   <= 1'b0;
            redirectValid  <= 1'b0;
            exceptionValid <= 1'b0;
        end else begin
            renameValid0   <= retire0 && !slot0.info.causeExc;
            renameValid1   <= retire1 && !slot1.info.causeExc;
            redirectValid  <= flush;
            exceptionValid <= exc0 || exc1;
        end
    end

    always_ff @(posedge clk) begin
        renameReq0 <= toReq(slot0.uop);
        renameReq1 <= toReq(slot1.uop);
        redirectPc <= redirectPcNext;
        excCode    <= excCodeNext;
    end

endmodule

// ==== hw/backendTop.sv ====
module backendTop #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         arstN,

    input  logic                         instValid,
    input  commitPkg::uopDesc            instIn,
    output logic                         instReady,

    input  logic                         compValid,
    input  logic [$clog2(ROB_DEPTH)-1:0] compTag,
    input  commitPkg::completionInfo     compInfo,

    output logic                         renameValid0,
    output logic                         renameValid1,
    output commitPkg::commitReq          renameReq0,
    output commitPkg::commitReq          renameReq1,
    output logic                         redirectValid,
    output logic [31:0]                  redirectPc,
    output logic                         exceptionValid,
    output logic [19:0]                  excCode
);

    logic                  allocValid;
    commitPkg::uopDesc     allocUop;
    commitPkg::commitWindow window;
    logic [1:0]            popCount;
    logic [1:0]            creditReturn;
    logic                  flush;

    dispatchUnit #(.ROB_DEPTH(ROB_DEPTH)) dispatch (
        .clk(clk), .arstN(arstN),
        .instValid(instValid), .instIn(instIn), .instReady(instReady),
        .creditReturn(creditReturn), .flush(flush),
        .allocValid(allocValid), .allocUop(allocUop)
    );

    reorderBuffer #(.ROB_DEPTH(ROB_DEPTH)) rob (
        .clk(clk), .arstN(arstN),
        .allocValid(allocValid), .allocUop(allocUop),
        .compValid(compValid), .compTag(compTag), .compInfo(compInfo),
        .window(window), .popCount(popCount), .flush(flush),
        .creditReturn(creditReturn)
    );

    commitStage commit (
        .clk(clk), .arstN(arstN),
        .window(window), .popCount(popCount), .flush(flush),
        .renameValid0(renameValid0), .renameValid1(renameValid1),
        .renameReq0(renameReq0), .renameReq1(renameReq1),
        .redirectValid(redirectValid), .redirectPc(redirectPc),
        .exceptionValid(exceptionValid), .excCode(excCode)
    );

endmodule

// ==== tb/backendVectors.svh ====
// Row columns: isBranch, predTaken, predTarget, taken, target, causeExc, excCode, expRename.
// Test columns: firstRow, numRows, expRedirect, expPc, expExc, expCode, fillCheck.

typedef struct packed {
    logic        isBranch;
    logic        predTaken;
    logic [31:0] predTarget;
    logic        taken;
    logic [31:0] target;
    logic        causeExc;
    logic [19:0] excCode;
    logic        expRename;
} vecRow;

typedef struct packed {
    logic [4:0]  firstRow;
    logic [3:0]  numRows;
    logic        expRedirect;
    logic [31:0] expPc;
    logic        expExc;
    logic [19:0] expCode;
    logic        fillCheck;
} vecTest;

localparam int NUM_ROWS  = 30;
localparam int NUM_TESTS = 7;

localparam vecRow ALU_OK  = {2'b00, 32'h0, 1'b0, 32'h0, 1'b0, 20'h0, 1'b1};
localparam vecRow ALU_OFF = {2'b00, 32'h0, 1'b0, 32'h0, 1'b0, 20'h0, 1'b0};  // Squashed.

localparam vecRow ROWS [NUM_ROWS] = '{
    ALU_OK, ALU_OK, ALU_OK, ALU_OK,
    ALU_OK, {2'b11, 32'h0040_0100, 1'b1, 32'h0040_0100, 1'b0, 20'h0, 1'b1}, ALU_OK,
    {2'b10, 32'h0040_0200, 1'b0, 32'h0, 1'b0, 20'h0, 1'b1}, ALU_OK,
    ALU_OK, {2'b10, 32'h0040_0300, 1'b1, 32'h0040_0300, 1'b0, 20'h0, 1'b1}, ALU_OK, ALU_OFF,
    {2'b11, 32'h0040_0400, 1'b0, 32'h0, 1'b0, 20'h0, 1'b1}, ALU_OK, ALU_OFF,
    {2'b11, 32'h0040_0500, 1'b1, 32'h0040_0600, 1'b0, 20'h0, 1'b1}, ALU_OK, ALU_OFF,
    ALU_OK, {2'b00, 32'h0, 1'b0, 32'h0, 1'b1, 20'h0000C, 1'b0}, ALU_OFF,
    ALU_OK, ALU_OK, ALU_OK, ALU_OK, ALU_OK, ALU_OK, ALU_OK, ALU_OK
};

localparam vecTest TESTS [NUM_TESTS] = '{
    {5'd0,  4'd4, 1'b0, 32'h0,                 1'b0, 20'h0,     1'b0},
    {5'd4,  4'd5, 1'b0, 32'h0,                 1'b0, 20'h0,     1'b0},
    {5'd9,  4'd4, 1'b1, 32'h0040_0300,         1'b0, 20'h0,     1'b0},
    {5'd13, 4'd3, 1'b1, 32'h0040_003C,         1'b0, 20'h0,     1'b0},  // Branch pc plus 8.
    {5'd16, 4'd3, 1'b1, 32'h0040_0600,         1'b0, 20'h0,     1'b0},
    {5'd19, 4'd3, 1'b1, commitPkg::EXC_VECTOR, 1'b1, 20'h0000C, 1'b0},
    {5'd22, 4'd8, 1'b0, 32'h0,                 1'b0, 20'h0,     1'b1}
};

string testNames [NUM_TESTS] = '{"inOrderAlu", "goodBranches", "dirMissTaken",
    "dirMissNotTaken", "targetMiss", "exception", "fillCredits"};

// ==== tb/backendTb.sv ====
module backendTb;
    timeunit 1ns;
    timeprecision 1ps;

    `include "backendVectors.svh"

    localparam int ROB_DEPTH   = 8;
    localparam int WATCHDOG_NS = (NUM_ROWS * 200 + 8) * 20;

    logic                     clk = 1'b0;
    logic                     arstN;
    logic                     instValid;
    commitPkg::uopDesc        instIn;
    logic                     instReady;
    logic                     compValid;
    logic [2:0]               compTag;
    commitPkg::completionInfo compInfo;
    logic                     renameValid0;
    logic                     renameValid1;
    commitPkg::commitReq      renameReq0;
    commitPkg::commitReq      renameReq1;
    logic                     redirectValid;
    logic [31:0]              redirectPc;
    logic                     exceptionValid;
    logic [19:0]              excCode;

    commitPkg::commitReq renameSeen[$];
    int                  redirectCount = 0;
    int                  excCount = 0;
    logic [31:0]         redirectPcSeen;
    logic [19:0]         excCodeSeen;
    int                  seed = 32'h3cab_6149;
    int                  errs = 0;
    int                  passCount = 0;
    int                  failCount = 0;
    logic [2:0]          nextTag = '0;
    logic [2:0]          tagOf [NUM_ROWS];

    backendTop #(.ROB_DEPTH(ROB_DEPTH)) UUT (.*);

    always #10 clk = ~clk;

    function automatic commitPkg::uopDesc uopOf(input int row);
        commitPkg::uopDesc uop;
        uop.pc           = 32'h0040_0000 + 32'(row * 4);
        uop.isBranch     = ROWS[row].isBranch;
        uop.predTaken    = ROWS[row].predTaken;
        uop.predTarget   = ROWS[row].predTarget;
        uop.dstArch      = 5'(row + 1);
        uop.dstPhys      = 6'(row + 32);
        uop.staleDstPhys = 6'(row);
        uop.writesDst    = (row % 3) != 0;
        return uop;
    endfunction

    function automatic commitPkg::completionInfo infoOf(input int row);
        commitPkg::completionInfo info;
        info = '0;
        info.causeExc = ROWS[row].causeExc;
        if (ROWS[row].isBranch) begin
            info.result.branch.taken  = ROWS[row].taken;
            info.result.branch.target = ROWS[row].target;
        end else begin
            info.result.exc.excCode = ROWS[row].excCode;
        end
        return info;
    endfunction

    // Expected request follows the register numbering given to each row.
    function automatic commitPkg::commitReq reqOf(input int row);
        commitPkg::commitReq req;
        req.committedArf = 5'(row + 1);
        req.committedPrf = 6'(row + 32);
        req.stalePrf     = 6'(row);
        req.wrRegCommit  = (row % 3) != 0;
        return req;
    endfunction

    task automatic dispatchRows(input int first, input int count, output int stalls);
        stalls = 0;
        for (int r = first; r < first + count; r++) begin
            while (!instReady) begin
                @(negedge clk);
                stalls++;
            end
            instValid = 1'b1;
            instIn    = uopOf(r);
            tagOf[r]  = nextTag;
            nextTag++;
            @(negedge clk);
        end
        instValid = 1'b0;
    endtask

    task automatic completeRow(input int row);
        compValid = 1'b1;
        compTag   = tagOf[row];
        compInfo  = infoOf(row);
        @(negedge clk);
        compValid = 1'b0;
    endtask

    task automatic reportTest(input string name);
        if (errs == 0) begin
            $display("%s: ok", name);
            passCount++;
        end else begin
            $display("%s: %0d errors", name, errs);
            failCount++;
        end
        errs = 0;
    endtask

    // Registered outputs are stable at the falling edge.
    always @(negedge clk) begin
        if (renameValid0) begin
            renameSeen.push_back(renameReq0);
        end
        if (renameValid1) begin
            renameSeen.push_back(renameReq1);
        end
        if (redirectValid) begin
            redirectCount++;
            redirectPcSeen = redirectPc;
        end
        if (exceptionValid) begin
            excCount++;
            excCodeSeen = excCode;
        end
        assert (renameValid0 || !renameValid1) else begin
            $display("Rename slot 1 was valid without slot 0");
            errs++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        vecTest              tst;
        string               name;
        int                  order [8];
        int                  first;
        int                  n;
        int                  lo;
        int                  j;
        int                  tmp;
        int                  stalls;
        int                  waited;
        int                  expCount;
        int                  idx;
        commitPkg::commitReq want;
        commitPkg::commitReq got;

        arstN     = 1'b0;
        instValid = 1'b0;
        instIn    = '0;
        compValid = 1'b0;
        compTag   = '0;
        compInfo  = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);
        assert (instReady && !renameValid0 && !renameValid1
                && !redirectValid && !exceptionValid) else begin
            $display("reset: instReady low or a commit output high after reset");
            errs++;
        end
        reportTest("reset");

        for (int t = 0; t < NUM_TESTS; t++) begin
            tst   = TESTS[t];
            name  = testNames[t];
            first = int'(tst.firstRow);
            n     = int'(tst.numRows);
            lo    = tst.fillCheck ? 1 : 0;  // Oldest completes first.
            for (int k = 0; k < n; k++) begin
                order[k] = first + k;
            end
            for (int i = n - 1; i > lo; i--) begin
                j        = lo + int'($unsigned($random(seed)) % (i - lo + 1));
                tmp      = order[i];
                order[i] = order[j];
                order[j] = tmp;
            end

            dispatchRows(first, n, stalls);
            if (tst.fillCheck) begin
                assert (stalls == 0) else begin
                    $display("%s: dispatch stalled before the buffer was full", name);
                    errs++;
                end
                assert (!instReady) else begin
                    $display("Fail %s instReady: expected 0, actual %b", name, instReady);
                    errs++;
                end
                completeRow(order[0]);
                waited = 0;
                while (!instReady && waited < 4) begin
                    @(negedge clk);
                    waited++;
                end
                assert (instReady) else begin
                    $display("%s: instReady stayed low after the oldest entry completed", name);
                    errs++;
                end
            end
            for (int k = lo; k < n; k++) begin
                completeRow(order[k]);
            end

            expCount = 0;
            for (int k = first; k < first + n; k++) begin
                expCount += int'(ROWS[k].expRename);
            end
            do @(posedge clk);
            while (renameSeen.size() < expCount || redirectCount < int'(tst.expRedirect)
                   || excCount < int'(tst.expExc));
            repeat (3) @(posedge clk);  // Catch late extra outputs.

            idx = 0;
            for (int k = first; k < first + n; k++) begin
                if (ROWS[k].expRename) begin
                    want = reqOf(k);
                    got  = (idx < renameSeen.size()) ? renameSeen[idx] : 'x;
                    assert (got === want) else begin
                        $display("Fail %s rename %0d: expected %h, actual %h",
                                 name, idx, want, got);
                        errs++;
                    end
                    idx++;
                end
            end
            assert (renameSeen.size() == expCount) else begin
                $display("Fail %s rename count: expected %0d, actual %0d",
                         name, expCount, renameSeen.size());
                errs++;
            end
            assert (redirectCount == int'(tst.expRedirect)) else begin
                $display("Fail %s redirect count: expected %0d, actual %0d",
                         name, tst.expRedirect, redirectCount);
                errs++;
            end
            if (tst.expRedirect) begin
                assert (redirectPcSeen === tst.expPc) else begin
                    $display("Fail %s redirectPc: expected %h, actual %h",
                             name, tst.expPc, redirectPcSeen);
                    errs++;
                end
                nextTag = '0;  // Tags restart after a flush.
            end
            assert (excCount == int'(tst.expExc)) else begin
                $display("Fail %s exception count: expected %0d, actual %0d",
                         name, tst.expExc, excCount);
                errs++;
            end
            if (tst.expExc) begin
                assert (excCodeSeen === tst.expCode) else begin
                    $display("Fail %s excCode: expected %h, actual %h",
                             name, tst.expCode, excCodeSeen);
                    errs++;
                end
            end
            reportTest(name);
            renameSeen.delete();
            redirectCount = 0;
            excCount      = 0;
            @(negedge clk);
        end

        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0 && errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+tb
common/commitPkg.sv
hw/dispatchUnit.sv
rob/reorderBuffer.sv
hw/commitStage.sv
hw/backendTop.sv
tb/backendTb.sv
